//--- wiscIsaPkg.sv
`default_nettype none

package wiscIsaPkg;

   localparam int NUM_REGS = 8;

   typedef logic [15:0] wiscWord_t;
   typedef logic [2:0]  wiscRegIdx_t;
   typedef logic [4:0]  wiscOpcode_t;    // Instruction bits 15 to 11
   typedef logic [1:0]  wiscFunct_t;     // R-format bits 1 to 0
   typedef logic [4:0]  wiscImm5_t;
   typedef logic [7:0]  wiscImm8_t;
   typedef logic [3:0]  wiscShamt_t;

   typedef enum logic [3:0] {
      ALU_RLL  = 4'b0000,
      ALU_SLL  = 4'b0001,
      ALU_SRA  = 4'b0010,
      ALU_SRL  = 4'b0011,
      ALU_ADD  = 4'b0100,
      ALU_AND  = 4'b0101,
      ALU_OR   = 4'b0110,
      ALU_XOR  = 4'b0111,
      ALU_SLBI = 4'b1000,
      ALU_BTR  = 4'b1001,
      ALU_RRL  = 4'b1010
   } aluOp_t;

   localparam wiscOpcode_t OP_ADDI  = 5'b01000;
   localparam wiscOpcode_t OP_SUBI  = 5'b01001;
   localparam wiscOpcode_t OP_XORI  = 5'b01010;
   localparam wiscOpcode_t OP_ANDNI = 5'b01011;
   localparam wiscOpcode_t OP_ROLI  = 5'b10100;
   localparam wiscOpcode_t OP_SLLI  = 5'b10101;
   localparam wiscOpcode_t OP_RORI  = 5'b10110;
   localparam wiscOpcode_t OP_SRLI  = 5'b10111;
   localparam wiscOpcode_t OP_SLBI  = 5'b10010;
   localparam wiscOpcode_t OP_BTR   = 5'b11001;
   localparam wiscOpcode_t OP_ALU   = 5'b11011;    // ADD SUB XOR ANDN
   localparam wiscOpcode_t OP_SHIFT = 5'b11010;    // ROL SLL ROR SRL

   localparam wiscFunct_t FN_ADD  = 2'b00;
   localparam wiscFunct_t FN_SUB  = 2'b01;
   localparam wiscFunct_t FN_XOR  = 2'b10;
   localparam wiscFunct_t FN_ANDN = 2'b11;
   localparam wiscFunct_t FN_ROL  = 2'b00;
   localparam wiscFunct_t FN_SLL  = 2'b01;
   localparam wiscFunct_t FN_ROR  = 2'b10;
   localparam wiscFunct_t FN_SRL  = 2'b11;

endpackage

`default_nettype wire

//--- wiscBusPkg.sv
`default_nettype none

package wiscBusPkg;

   import wiscIsaPkg::*;

   typedef logic [3:0] wbAddr_t;    // Word address

   typedef struct packed {
      logic      cyc;
      logic      stb;
      logic      we;
      wbAddr_t   adr;
      wiscWord_t dat_w;
   } wbReq_t;

   typedef struct packed {
      logic      ack;
      wiscWord_t dat_r;
   } wbRsp_t;

   typedef struct packed {
      logic      instrValid;    // One-cycle launch pulse
      wiscWord_t instr;
   } execReq_t;

   typedef struct packed {
      logic [7:0] instrCount;      // Legal instructions run
      logic [6:0] illegalCount;
      logic       lastIllegal;     // Set by the most recent instruction
   } status_t;

   // Registers sit at addresses 0 to NUM_REGS-1
   localparam wbAddr_t ADR_INSTR  = 4'd8;
   localparam wbAddr_t ADR_STATUS = 4'd9;

endpackage

`default_nettype wire

//--- wbHostPort.sv
`timescale 1ns/100ps
`default_nettype none

module wbHostPort
   import wiscIsaPkg::*, wiscBusPkg::*;
(
   input  logic        clk,
   input  logic        rstN,
   input  wbReq_t      wbReq,
   input  logic        done,
   input  status_t     status,
   input  wiscWord_t   hostRdData,
   output wbRsp_t      wbRsp,
   output execReq_t    execReq,
   output logic        hostWe,
   output wiscRegIdx_t hostIdx,
   output wiscWord_t   hostData
);

   typedef enum logic [1:0] {
      IDLE,
      EXEC,
      ACK
   } state_t;

   state_t    state;
   logic      accept;
   logic      isReg;
   logic      instrWrite;
   logic      instrValidQ;
   wiscWord_t instrQ;
   wiscWord_t rdMux;
   wiscWord_t datR;

   assign accept     = (state == IDLE) && wbReq.cyc && wbReq.stb;
   assign isReg      = wbReq.adr < wbAddr_t'(NUM_REGS);
   assign instrWrite = wbReq.we && (wbReq.adr == ADR_INSTR);

   // Host writes land on the accepting edge
   assign hostIdx  = wbReq.adr[2:0];
   assign hostData = wbReq.dat_w;
   assign hostWe   = accept && wbReq.we && isReg;

   always_comb
   begin
      if (isReg)
         rdMux = hostRdData;
      else if (wbReq.adr == ADR_STATUS)
         rdMux = status;
      else
         rdMux = '0;    // Instruction word is write only
   end

   always_ff @(posedge clk)
   begin
      if (!rstN)
      begin
         state       <= IDLE;
         instrValidQ <= 1'b0;
      end
      else
      begin
         instrValidQ <= accept && instrWrite;
         case (state)
            IDLE:    if (accept) state <= instrWrite ? EXEC : ACK;
            EXEC:    if (done) state <= ACK;    // Writeback lands on this edge
            ACK:     state <= IDLE;
            default: state <= IDLE;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (accept)
      begin
         datR   <= wbReq.we ? '0 : rdMux;
         instrQ <= wbReq.dat_w;
      end
   end

   assign execReq = '{instrValid: instrValidQ, instr: instrQ};
   assign wbRsp   = '{ack: (state == ACK), dat_r: datR};

   // The master holds its request until the ack
   ackNeedsReq: assert property (@(posedge clk) disable iff (!rstN)
      wbRsp.ack |-> (wbReq.cyc && wbReq.stb));

endmodule

`default_nettype wire

//--- aluOpDecode.sv
`timescale 1ns/100ps
`default_nettype none

module aluOpDecode
   import wiscIsaPkg::*;
(
   input  wiscWord_t instruction,
   output aluOp_t    aluOp
);

   wiscOpcode_t opcode;
   wiscFunct_t  funct;

   assign opcode = instruction[15:11];
   assign funct  = instruction[1:0];

   always_comb
   begin
      aluOp = ALU_RLL;
      case (opcode)
         OP_ADDI:  aluOp = ALU_ADD;
         OP_SUBI:  aluOp = ALU_ADD;    // Core inverts Rs
         OP_XORI:  aluOp = ALU_XOR;
         OP_ANDNI: aluOp = ALU_AND;    // Core inverts the immediate
         OP_ROLI:  aluOp = ALU_RLL;
         OP_SLLI:  aluOp = ALU_SLL;
         OP_RORI:  aluOp = ALU_RRL;
         OP_SRLI:  aluOp = ALU_SRL;
         OP_SLBI:  aluOp = ALU_SLBI;
         OP_BTR:   aluOp = ALU_BTR;
         OP_ALU:
         begin
            case (funct)
               FN_ADD:  aluOp = ALU_ADD;
               FN_SUB:  aluOp = ALU_ADD;
               FN_XOR:  aluOp = ALU_XOR;
               FN_ANDN: aluOp = ALU_AND;
               default: aluOp = ALU_ADD;
            endcase
         end
         OP_SHIFT:
         begin
            case (funct)
               FN_ROL:  aluOp = ALU_RLL;
               FN_SLL:  aluOp = ALU_SLL;
               FN_ROR:  aluOp = ALU_RRL;
               FN_SRL:  aluOp = ALU_SRL;
               default: aluOp = ALU_RLL;
            endcase
         end
         default:  aluOp = ALU_RLL;    // Unsupported groups
      endcase
   end

endmodule

`default_nettype wire

//--- wiscAlu.sv
`timescale 1ns/100ps
`default_nettype none

module wiscAlu
   import wiscIsaPkg::*;
(
   input  aluOp_t    aluOp,
   input  wiscWord_t a,
   input  wiscWord_t b,
   input  logic      cin,
   output wiscWord_t result
);

   wiscShamt_t  shamt;
   logic [31:0] dblWord;
   logic [31:0] rolWide;
   logic [31:0] rorWide;
   wiscWord_t   sum;
   wiscWord_t   reversed;

   assign shamt   = b[3:0];
   assign dblWord = {a, a};

   // Rotates come out of the low half of the doubled word
   assign rolWide = dblWord >> (5'd16 - {1'b0, shamt});
   assign rorWide = dblWord >> shamt;

   assign sum      = a + b + wiscWord_t'(cin);
   assign reversed = {<<{a}};

   always_comb
   begin
      case (aluOp)
         ALU_RLL:  result = rolWide[15:0];
         ALU_SLL:  result = a << shamt;
         ALU_SRA:  result = $signed(a) >>> shamt;
         ALU_SRL:  result = a >> shamt;
         ALU_ADD:  result = sum;
         ALU_AND:  result = a & b;
         ALU_OR:   result = a | b;
         ALU_XOR:  result = a ^ b;
         ALU_SLBI: result = {a[7:0], b[7:0]};    // Low byte of b merged in
         ALU_BTR:  result = reversed;
         ALU_RRL:  result = rorWide[15:0];
         default:  result = '0;
      endcase
   end

endmodule

`default_nettype wire

//--- wiscExecCore.sv
`timescale 1ns/100ps
`default_nettype none

module wiscExecCore
   import wiscIsaPkg::*, wiscBusPkg::*;
(
   input  logic        clk,
   input  logic        rstN,
   input  execReq_t    execReq,
   input  wiscWord_t   rdDataA,
   input  wiscWord_t   rdDataB,
   output wiscRegIdx_t rdIdxA,
   output wiscRegIdx_t rdIdxB,
   output logic        wbEn,
   output wiscRegIdx_t wbIdx,
   output wiscWord_t   wbData,
   output logic        done,
   output status_t     status
);

   wiscWord_t   instr;
   wiscOpcode_t opcode;
   wiscFunct_t  funct;
   wiscImm5_t   imm5;
   wiscImm8_t   imm8;
   wiscWord_t   immExt;
   wiscWord_t   opB;
   wiscWord_t   aluA;
   wiscWord_t   aluB;
   wiscWord_t   aluResult;
   wiscRegIdx_t dstIdx;
   aluOp_t      aluOp;
   logic        isRType;
   logic        legal;
   logic        invA;
   logic        invB;

   assign instr  = execReq.instr;
   assign opcode = instr[15:11];
   assign funct  = instr[1:0];
   assign imm5   = instr[4:0];
   assign imm8   = instr[7:0];
   assign rdIdxA = instr[10:8];    // Rs
   assign rdIdxB = instr[7:5];     // Rt

   always_comb
   begin
      legal   = 1'b1;
      isRType = 1'b0;
      immExt  = wiscWord_t'(imm5);
      dstIdx  = instr[7:5];
      case (opcode)
         OP_ADDI, OP_SUBI:
            immExt = {{11{imm5[4]}}, imm5};
         OP_XORI, OP_ANDNI, OP_ROLI, OP_SLLI, OP_RORI, OP_SRLI:
            immExt = wiscWord_t'(imm5);
         OP_SLBI:
         begin
            immExt = wiscWord_t'(imm8);
            dstIdx = instr[10:8];    // Rs is also the destination
         end
         OP_BTR, OP_ALU, OP_SHIFT:
         begin
            isRType = 1'b1;
            dstIdx  = instr[4:2];
         end
         default:
            legal = 1'b0;
      endcase
   end

   // SUBI and SUB take the two's complement of Rs
   assign invA = (opcode == OP_SUBI) || ((opcode == OP_ALU) && (funct == FN_SUB));
   assign invB = (opcode == OP_ANDNI) || ((opcode == OP_ALU) && (funct == FN_ANDN));

   assign opB  = isRType ? rdDataB : immExt;
   assign aluA = invA ? ~rdDataA : rdDataA;
   assign aluB = invB ? ~opB : opB;

   aluOpDecode decode (
      .instruction(instr),
      .aluOp      (aluOp)
   );

   wiscAlu alu (
      .aluOp (aluOp),
      .a     (aluA),
      .b     (aluB),
      .cin   (invA),
      .result(aluResult)
   );

   always_ff @(posedge clk)
   begin
      if (!rstN)
      begin
         wbEn   <= 1'b0;
         done   <= 1'b0;
         status <= '0;
      end
      else
      begin
         wbEn <= execReq.instrValid && legal;
         done <= execReq.instrValid;
         if (execReq.instrValid)
         begin
            if (legal)
               status.instrCount <= status.instrCount + 1'b1;
            else
               status.illegalCount <= status.illegalCount + 1'b1;
            status.lastIllegal <= !legal;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (execReq.instrValid)
      begin
         wbIdx  <= dstIdx;
         wbData <= aluResult;
      end
   end

   // Host port launches only after the previous writeback retired
   noLaunchDuringWb: assert property (@(posedge clk) disable iff (!rstN)
      execReq.instrValid |-> !wbEn);

endmodule

`default_nettype wire

//--- wiscRegFile.sv
`timescale 1ns/100ps
`default_nettype none

module wiscRegFile
   import wiscIsaPkg::*;
(
   input  logic        clk,
   input  logic        rstN,
   input  wiscRegIdx_t rdIdxA,
   input  wiscRegIdx_t rdIdxB,
   input  wiscRegIdx_t hostIdx,
   input  logic        wbEn,
   input  logic        hostWe,
   input  wiscRegIdx_t wbIdx,
   input  wiscWord_t   wbData,
   input  wiscWord_t   hostData,
   output wiscWord_t   rdDataA,
   output wiscWord_t   rdDataB,
   output wiscWord_t   hostRdData
);

   wiscWord_t regs [NUM_REGS];

   always_ff @(posedge clk)
   begin
      if (!rstN)
         regs <= '{default: '0};
      else if (wbEn)
         regs[wbIdx] <= wbData;       // Writeback from the core
      else if (hostWe)
         regs[hostIdx] <= hostData;
   end

   assign rdDataA    = regs[rdIdxA];
   assign rdDataB    = regs[rdIdxB];
   assign hostRdData = regs[hostIdx];

   // Host accesses and instruction writebacks are serialized by the bus port
   oneWriter: assert property (@(posedge clk) disable iff (!rstN)
      !(wbEn && hostWe));

endmodule

`default_nettype wire

//--- wiscExecTop.sv
`timescale 1ns/100ps
`default_nettype none

module wiscExecTop
   import wiscIsaPkg::*, wiscBusPkg::*;
(
   input  logic   clk,
   input  logic   rstN,
   input  wbReq_t wbReq,
   output wbRsp_t wbRsp
);

   execReq_t    execReq;
   status_t     status;
   logic        done;
   logic        wbEn;
   logic        hostWe;
   wiscRegIdx_t rdIdxA;
   wiscRegIdx_t rdIdxB;
   wiscRegIdx_t wbIdx;
   wiscRegIdx_t hostIdx;
   wiscWord_t   rdDataA;
   wiscWord_t   rdDataB;
   wiscWord_t   wbData;
   wiscWord_t   hostData;
   wiscWord_t   hostRdData;

   wbHostPort hostPort (
      .clk       (clk),
      .rstN      (rstN),
      .wbReq     (wbReq),
      .done      (done),
      .status    (status),
      .hostRdData(hostRdData),
      .wbRsp     (wbRsp),
      .execReq   (execReq),
      .hostWe    (hostWe),
      .hostIdx   (hostIdx),
      .hostData  (hostData)
   );

   wiscExecCore core (
      .clk    (clk),
      .rstN   (rstN),
      .execReq(execReq),
      .rdDataA(rdDataA),
      .rdDataB(rdDataB),
      .rdIdxA (rdIdxA),
      .rdIdxB (rdIdxB),
      .wbEn   (wbEn),
      .wbIdx  (wbIdx),
      .wbData (wbData),
      .done   (done),
      .status (status)
   );

   wiscRegFile regFile (
      .clk       (clk),
      .rstN      (rstN),
      .rdIdxA    (rdIdxA),
      .rdIdxB    (rdIdxB),
      .hostIdx   (hostIdx),
      .wbEn      (wbEn),
      .hostWe    (hostWe),
      .wbIdx     (wbIdx),
      .wbData    (wbData),
      .hostData  (hostData),
      .rdDataA   (rdDataA),
      .rdDataB   (rdDataB),
      .hostRdData(hostRdData)
   );

endmodule

`default_nettype wire

//--- wiscExecTb.sv
`timescale 1ns/100ps
`default_nettype none

module wiscExecTb
   import wiscIsaPkg::*, wiscBusPkg::*;
();

   localparam int RESET_CYCLES = 5;
   localparam int MAX_CASES    = 64;
   localparam int ACK_LIMIT    = 4;
   localparam int CASE_CYCLES  = 8;    // Budget for one access plus its idle gap

   logic      clk = 1'b0;
   logic      rstN;
   wbReq_t    wbReq;
   wbRsp_t    wbRsp;
   logic [7:0] caseKind [MAX_CASES];
   wiscWord_t caseArg  [MAX_CASES];
   wiscWord_t caseData [MAX_CASES];
   int        numCases    = 0;
   int        valueErrors = 0;
   int        ackErrors   = 0;
   int        fileErrors  = 0;
   int        cycleCount  = 0;
   int        cycleLimit  = RESET_CYCLES;
   logic [31:0] lfsr      = 32'h00e64992;

   always #4 clk = ~clk;

   wiscExecTop uut (
      .clk  (clk),
      .rstN (rstN),
      .wbReq(wbReq),
      .wbRsp(wbRsp)
   );

   // Taps 32, 22, 2, 1
   function automatic logic [31:0] lfsrStep(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic takeGap(output int gap);
      gap = 0;
      repeat (2)
      begin
         lfsr = lfsrStep(lfsr);
         gap  = (gap << 1) | int'(lfsr[0]);
      end
   endtask

   task automatic checkWord(input wiscWord_t got, input wiscWord_t exp, input wbAddr_t adr);
      if (got !== exp)
      begin
         valueErrors++;
         $display("ERROR %0t: read of address %0h gave %h, expected %h", $time, adr, got, exp);
      end
   endtask

   task automatic checkStatus(input status_t got, input status_t exp);
      if (got !== exp)
      begin
         valueErrors++;
         $display("ERROR %0t: status count %0d illegal %0d last %b, expected %0d %0d %b",
                  $time, got.instrCount, got.illegalCount, got.lastIllegal,
                  exp.instrCount, exp.illegalCount, exp.lastIllegal);
      end
   endtask

   // One Wishbone classic access, held until the ack has been sampled
   task automatic busAccess(input logic we, input wbAddr_t adr, input wiscWord_t datW,
                            output wiscWord_t datR);
      int waited;
      waited      = 0;
      datR        = '0;
      wbReq.cyc   = 1'b1;
      wbReq.stb   = 1'b1;
      wbReq.we    = we;
      wbReq.adr   = adr;
      wbReq.dat_w = datW;
      do
      begin
         @(posedge clk);
         #1;
         waited++;
      end
      while (!wbRsp.ack && waited < ACK_LIMIT);
      if (wbRsp.ack)
         datR = wbRsp.dat_r;
      else
      begin
         ackErrors++;
         $display("No acknowledge within %0d cycles for address %0h", ACK_LIMIT, adr);
      end
      @(posedge clk);    // Master sees the ack on this edge
      #1;
      wbReq = '0;
   endtask

   always @(posedge clk)
   begin
      cycleCount = cycleCount + 1;
      if (cycleCount >= cycleLimit)
      begin
         $display("Run stopped at cycle %0d before all cases were done", cycleCount);
         $display("Test failed");
         $finish;
      end
   end

   initial
   begin : mainFlow
      int         fd;
      int         code;
      int         gap;
      string      line;
      logic [7:0] kind;
      wiscWord_t  arg;
      wiscWord_t  data;
      wiscWord_t  rdData;
      wbReq = '0;
      rstN  = 1'b0;
      fd    = $fopen("wiscExecCases.txt", "r");
      if (fd == 0)
      begin
         fileErrors++;
         $display("Could not open the cases file wiscExecCases.txt");
      end
      else
      begin
         while (!$feof(fd) && numCases < MAX_CASES)
         begin
            code = $fgets(line, fd);
            if (code > 0 && line.len() > 1 && line.substr(0, 1) != "//")
            begin
               code = $sscanf(line, "%c %h %h", kind, arg, data);
               if (code == 3)
               begin
                  caseKind[numCases] = kind;
                  caseArg[numCases]  = arg;
                  caseData[numCases] = data;
                  numCases++;
               end
               else
               begin
                  fileErrors++;
                  $display("Cases file line could not be parsed: %s", line);
               end
            end
         end
         $fclose(fd);
      end
      cycleLimit = numCases * CASE_CYCLES + RESET_CYCLES;

      repeat (RESET_CYCLES) @(posedge clk);
      #1;
      rstN = 1'b1;

      for (int i = 0; i < numCases; i++)
      begin
         takeGap(gap);
         repeat (gap)
         begin
            @(posedge clk);
            #1;
         end
         case (caseKind[i])
            "W": busAccess(1'b1, wbAddr_t'(caseArg[i]), caseData[i], rdData);
            "I": busAccess(1'b1, ADR_INSTR, caseArg[i], rdData);
            "R":
            begin
               busAccess(1'b0, wbAddr_t'(caseArg[i]), '0, rdData);
               checkWord(rdData, caseData[i], wbAddr_t'(caseArg[i]));
            end
            "S":
            begin
               busAccess(1'b0, ADR_STATUS, '0, rdData);
               checkStatus(status_t'(rdData), status_t'(caseData[i]));
            end
            default:
            begin
               fileErrors++;
               $display("Case %0d has an unknown kind %c", i, caseKind[i]);
            end
         endcase
      end

      $display("Value errors %0d, missing acks %0d, file errors %0d over %0d cases",
               valueErrors, ackErrors, fileErrors, numCases);
      if (valueErrors + ackErrors + fileErrors == 0 && numCases > 0)
         $display("Test passed");
      else
         $display("Test failed");
      $finish;
   end

endmodule

`default_nettype wire

//--- wiscExecCases.txt
// kind: W reg write, I instruction, R reg read, S status read
// then address or instruction word, then write data or expected value (hex)
R 5 0000
W 1 1234
W 3 8001
R 3 8001
I 419d 0000
I 4ca5 0000
R 5 edd4
I 55df 0000
I 5ef6 0000
R 7 edc9
I a344 0000
I aa83 0000
I b4a7 0000
R 5 8001
I bdcf 0000
I d6a1 0000
R 0 0002
I d97c 0000
I dce9 0000
I df52 0000
R 4 0340
I da97 0000
R 5 9035
I 93a5 0000
I cb18 0000
R 6 a580
I 89c0 0000
I 6600 0000
I e158 0000
R 6 a580
S 9 0f07
R c 0000

//--- wiscExecTop.f
wiscIsaPkg.sv
wiscBusPkg.sv
wbHostPort.sv
aluOpDecode.sv
wiscAlu.sv
wiscExecCore.sv
wiscRegFile.sv
wiscExecTop.sv
wiscExecTb.sv

//--- Bender.yml
package:
  name: wisc_exec

sources:
  - wiscIsaPkg.sv
  - wiscBusPkg.sv
  - wbHostPort.sv
  - aluOpDecode.sv
  - wiscAlu.sv
  - wiscExecCore.sv
  - wiscRegFile.sv
  - wiscExecTop.sv
  - target: test
    files:
      - wiscExecTb.sv
